// File: Makefile
# Verilator build and run for the dual_port_mem testbench

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := tb_dual_port_mem
FILELIST  := sources.f
OBJ_DIR   := obj_dir
BIN       := $(OBJ_DIR)/V$(TOP)
PASS_TEXT := STATUS: PASS

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx '$(PASS_TEXT)'

clean:
	rm -rf $(OBJ_DIR)

// File: design/bank_array.sv
// bank_array, eight bank_ram instances with bank-select write steering and address field split
`timescale 1ns/1ps
`default_nettype none

module bank_array (
	input wire logic rclk,
	input wire logic reset,
	// port A
	input wire logic [mem_pkg::a_addr_bits-1:0] a_address,
	input wire mem_pkg::word_t a_write_data,
	input wire logic a_write_enable,
	// port B
	input wire logic [mem_pkg::b_addr_bits-1:0] b_address,
	// per-bank read results, one cycle after the address
	output mem_pkg::word_t a_bank_words [mem_pkg::bank_count],
	output mem_pkg::byte_t b_bank_bytes [mem_pkg::bank_count]
);
	import mem_pkg::*;

	// port A fields
	bank_sel_t a_bank;
	logic [word_addr_bits-1:0] a_word;

	// port B fields, bank is picked later in read_select
	logic [word_addr_bits-1:0] b_word;
	logic [lane_bits-1:0] b_lane;

	// one write strobe per bank
	logic [bank_count-1:0] bank_write_enable;

	// bank on top, word index below
	assign a_bank = a_address[a_addr_bits-1 -: bank_bits];
	assign a_word = a_address[word_addr_bits-1:0];

	// word index sits above the lane bits
	assign b_word = b_address[lane_bits +: word_addr_bits];
	assign b_lane = b_address[lane_bits-1:0];

	for (genvar i = 0; i < bank_count; i++) begin : g_bank
		// only the named bank sees the strobe
		assign bank_write_enable[i] = a_write_enable && (a_bank == bank_sel_t'(i));

		// every bank reads every cycle
		// read_select throws away the ones not addressed
		bank_ram i_bank_ram (
			.rclk (rclk),
			.reset (reset),
			.write_enable (bank_write_enable[i]),
			.a_word (a_word),
			.write_data (a_write_data),
			.a_read_data (a_bank_words[i]),
			.b_word (b_word),
			.b_lane (b_lane),
			.b_read_data (b_bank_bytes[i])
		);
	end

	// a strobe lands in exactly one bank, never two and never none
	single_bank_write: assert property (
		@(posedge rclk) disable iff (reset)
		$onehot0(bank_write_enable) && ((|bank_write_enable) == a_write_enable)
	);

endmodule

`default_nettype wire

// File: design/bank_ram.sv
// bank_ram, one 512-word bank with a word read/write port and a registered byte read port
`timescale 1ns/1ps
`default_nettype none

module bank_ram (
	input wire logic rclk,
	input wire logic reset,
	// port A, whole words
	input wire logic write_enable,
	input wire logic [mem_pkg::word_addr_bits-1:0] a_word,
	input wire mem_pkg::word_t write_data,
	output mem_pkg::word_t a_read_data,
	// port B, single bytes from the same words
	input wire logic [mem_pkg::word_addr_bits-1:0] b_word,
	input wire logic [mem_pkg::lane_bits-1:0] b_lane,
	output mem_pkg::byte_t b_read_data
);
	import mem_pkg::*;

	// inferred storage, no reset on the array itself
	bank_word_u mem [0:(1 << word_addr_bits)-1];

	// port B read register holds the full word
	bank_word_u b_word_q;
	// lane travels with the read so the pick lines up
	logic [lane_bits-1:0] b_lane_q;

	// write side
	always_ff @(posedge rclk) begin
		if (write_enable) begin
			mem[a_word].word <= write_data;
		end
	end

	// port A read register
	// nonblocking write above means a same-cycle read sees the old word
	always_ff @(posedge rclk) begin
		if (reset) begin
			a_read_data <= '0;
		end else begin
			a_read_data <= mem[a_word].word;
		end
	end

	// port B read register and its lane
	always_ff @(posedge rclk) begin
		if (reset) begin
			b_word_q <= '0;
			b_lane_q <= '0;
		end else begin
			b_word_q <= mem[b_word];
			b_lane_q <= b_lane;
		end
	end

	// byte view of the registered word
	assign b_read_data = b_word_q.lanes[b_lane_q];

	// a write to an unknown index would corrupt an unknown word
	a_write_index_known: assert property (
		@(posedge rclk) disable iff (reset)
		write_enable |-> !$isunknown(a_word)
	);

endmodule

`default_nettype wire

// File: design/dual_port_mem.sv
// dual_port_mem, top level with the bank array, two read selects and the control window
`timescale 1ns/1ps
`default_nettype none

module dual_port_mem (
	input wire logic rclk,
	input wire logic reset,
	// port A, 32-bit words, read and write
	input wire logic [mem_pkg::a_addr_bits-1:0] a_address,
	input wire mem_pkg::word_t a_write_data,
	input wire logic a_write_enable,
	output mem_pkg::word_t a_read_data,
	// port B, bytes, read only
	input wire logic [mem_pkg::b_addr_bits-1:0] b_address,
	output mem_pkg::byte_t b_read_data,
	// control window outputs
	output mem_pkg::word_t control_0,
	output mem_pkg::word_t control_1,
	output mem_pkg::word_t control_2,
	output mem_pkg::word_t control_3
);
	import mem_pkg::*;

	// bank outputs, one cycle after the address
	word_t a_bank_words [bank_count];
	byte_t b_bank_bytes [bank_count];

	// bank fields for the two output multiplexers
	bank_sel_t a_bank;
	bank_sel_t b_bank;

	assign a_bank = a_address[a_addr_bits-1 -: bank_bits];
	assign b_bank = b_address[b_addr_bits-1 -: bank_bits];

	bank_array i_bank_array (
		.rclk (rclk),
		.reset (reset),
		.a_address (a_address),
		.a_write_data (a_write_data),
		.a_write_enable (a_write_enable),
		.b_address (b_address),
		.a_bank_words (a_bank_words),
		.b_bank_bytes (b_bank_bytes)
	);

	// port A output stage, full words
	read_select #(.data_width(word_width)) port_a_select (
		.rclk (rclk),
		.reset (reset),
		.bank (a_bank),
		.bank_data (a_bank_words),
		.read_data (a_read_data)
	);

	// port B output stage, single bytes
	read_select #(.data_width(byte_width)) port_b_select (
		.rclk (rclk),
		.reset (reset),
		.bank (b_bank),
		.bank_data (b_bank_bytes),
		.read_data (b_read_data)
	);

	// shadows writes to bank 0 words 0 to 3
	register_window i_register_window (
		.rclk (rclk),
		.reset (reset),
		.a_address (a_address),
		.a_write_data (a_write_data),
		.a_write_enable (a_write_enable),
		.control_0 (control_0),
		.control_1 (control_1),
		.control_2 (control_2),
		.control_3 (control_3)
	);

endmodule

`default_nettype wire

// File: design/mem_pkg.sv
// memory geometry constants, address field widths, data types and the bank word union
`default_nettype none

package mem_pkg;

	// storage and port widths
	localparam int word_width = 32;
	localparam int byte_width = 8;

	// bank arrangement, eight banks of 512 words
	localparam int bank_count = 8;
	localparam int bank_bits = $clog2(bank_count);
	localparam int word_addr_bits = 9;

	// byte lane within a stored word
	localparam int lane_bits = $clog2(word_width / byte_width);

	// port A addresses words, bank in the top bits
	localparam int a_addr_bits = bank_bits + word_addr_bits;

	// port B addresses bytes, lane in the low bits
	localparam int b_addr_bits = bank_bits + word_addr_bits + lane_bits;

	// control registers shadow the bottom words of bank 0
	localparam int control_count = 4;

	typedef logic [word_width-1:0] word_t;
	typedef logic [byte_width-1:0] byte_t;
	typedef logic [bank_bits-1:0] bank_sel_t;

	// one stored word, read whole by port A and by lane on port B
	// lane 0 sits in the least significant byte
	typedef union packed {
		word_t word;
		byte_t [(1 << lane_bits)-1:0] lanes;
	} bank_word_u;

endpackage

`default_nettype wire

// File: design/read_select.sv
// read_select, registered bank select, bank output multiplexer and output register
`timescale 1ns/1ps
`default_nettype none

module read_select #(
	parameter int data_width = mem_pkg::word_width
) (
	input wire logic rclk,
	input wire logic reset,
	// bank field of the address, same cycle as the bank address
	input wire mem_pkg::bank_sel_t bank,
	// one result per bank, one cycle after the address
	input wire logic [data_width-1:0] bank_data [mem_pkg::bank_count],
	output logic [data_width-1:0] read_data
);
	import mem_pkg::*;

	// bank number delayed to match the bank read register
	bank_sel_t bank_q;

	// bank_q loads on the edge that performs the bank read
	always_ff @(posedge rclk) begin
		if (reset) begin
			bank_q <= '0;
		end else begin
			bank_q <= bank;
		end
	end

	// pick the addressed bank and register it
	// adds the second cycle of read latency
	always_ff @(posedge rclk) begin
		if (reset) begin
			read_data <= '0;
		end else begin
			read_data <= bank_data[bank_q];
		end
	end

	// output starts from zero after reset
	// whatever the banks were holding
	read_data_cleared: assert property (
		@(posedge rclk)
		reset |=> (read_data == '0)
	);

endmodule

`default_nettype wire

// File: design/register_window.sv
// four control registers shadowing port A writes to the bottom of bank 0
`timescale 1ns/1ps
`default_nettype none

module register_window (
	input wire logic rclk,
	input wire logic reset,
	input wire logic [mem_pkg::a_addr_bits-1:0] a_address,
	input wire mem_pkg::word_t a_write_data,
	input wire logic a_write_enable,
	output mem_pkg::word_t control_0,
	output mem_pkg::word_t control_1,
	output mem_pkg::word_t control_2,
	output mem_pkg::word_t control_3
);
	import mem_pkg::*;

	// address fields split as in the banks
	bank_sel_t a_bank;
	logic [word_addr_bits-1:0] a_word;

	// any port A write into bank 0
	logic window_write;
	// per-register load strobes
	logic [control_count-1:0] load;

	word_t control_q [control_count];

	assign a_bank = a_address[a_addr_bits-1 -: bank_bits];
	assign a_word = a_address[word_addr_bits-1:0];
	assign window_write = a_write_enable && (a_bank == '0);

	for (genvar i = 0; i < control_count; i++) begin : g_control
		// word i of bank 0 only
		assign load[i] = window_write && (a_word == word_addr_bits'(i));

		// loads on the same edge as the memory write
		always_ff @(posedge rclk) begin
			if (reset) begin
				control_q[i] <= '0;
			end else if (load[i]) begin
				control_q[i] <= a_write_data;
			end
		end

		// bank 0 word i is port A address i
		// a change needs that write or a reset one edge earlier
		control_change_has_cause: assert property (
			@(posedge rclk) disable iff (reset)
			!$stable(control_q[i]) |->
				($past(a_write_enable && (a_address == a_addr_bits'(i))) || $past(reset))
		);
	end

	assign control_0 = control_q[0];
	assign control_1 = control_q[1];
	assign control_2 = control_q[2];
	assign control_3 = control_q[3];

endmodule

`default_nettype wire

// File: sources.f
+incdir+verification
design/mem_pkg.sv
design/bank_ram.sv
design/bank_array.sv
design/read_select.sv
design/register_window.sv
design/dual_port_mem.sv
verification/tb_dual_port_mem.sv

// File: verification/tb_checks.svh
// compare tasks, expected-memory model and error counters for the dual_port_mem testbench
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

// running totals for the closing line
int error_count = 0;
int check_count = 0;

// expected memory keyed by port A word address
// only written locations have an entry
word_t model_mem [int];

// expected control outputs
word_t model_control [control_count] = '{default: '0};

// true when the word has been written at least once
function automatic bit model_has(input logic [a_addr_bits-1:0] addr);
	return model_mem.exists(int'(addr)) != 0;
endfunction

function automatic word_t model_word(input logic [a_addr_bits-1:0] addr);
	return model_mem[int'(addr)];
endfunction

// byte address is word address with the lane below it
// lane n is bits 8n up to 8n+7
function automatic byte_t model_byte(input logic [b_addr_bits-1:0] addr);
	logic [a_addr_bits-1:0] word_addr;
	int lane;
	word_t stored;
	word_addr = addr[b_addr_bits-1 -: a_addr_bits];
	lane = int'(addr[lane_bits-1:0]);
	stored = model_mem[int'(word_addr)];
	return stored[byte_width*lane +: byte_width];
endfunction

// bank 0 words 0 to 3 also land in the control registers
task automatic model_write(input logic [a_addr_bits-1:0] addr, input word_t data);
	model_mem[int'(addr)] = data;
	if (addr[a_addr_bits-1 -: bank_bits] == '0
			&& int'(addr[word_addr_bits-1:0]) < control_count) begin
		model_control[int'(addr[word_addr_bits-1:0])] = data;
	end
endtask

task automatic compare_word(input string signal_name, input word_t actual, input word_t expected);
	check_count++;
	if (actual !== expected) begin
		error_count++;
		$display("FAIL at %0t: %s is %h, expected %h", $time, signal_name, actual, expected);
	end
endtask

task automatic compare_byte(input string signal_name, input byte_t actual, input byte_t expected);
	check_count++;
	if (actual !== expected) begin
		error_count++;
		$display("FAIL at %0t: %s is %h, expected %h", $time, signal_name, actual, expected);
	end
endtask

task automatic compare_control(input int index, input word_t actual, input word_t expected);
	check_count++;
	if (actual !== expected) begin
		error_count++;
		$display("FAIL at %0t: control_%0d is %h, expected %h", $time, index, actual, expected);
	end
endtask

`endif

// File: verification/tb_dual_port_mem.sv
// tb_dual_port_mem, clock, reset, DUT, directed test tasks, timeout and summary
`timescale 1ns/1ps
`default_nettype none

module tb_dual_port_mem;
	import mem_pkg::*;

	localparam int clock_period = 8;
	localparam int reset_cycles = 10;
	localparam int random_seed = 32'h944d61a8;
	localparam int word_count = 16;
	localparam int burst_length = 40;
	localparam int rbw_count = 4;
	// one stage per cycle between drive and check
	localparam int pipe_depth = 3;
	localparam int drain = pipe_depth - 1;
	// cycles per test, used for the run limit
	localparam int test_cycles = (reset_cycles + 1) + (2 * word_count + drain)
		+ (4 * word_count + drain) + (burst_length + drain)
		+ (2 * rbw_count + drain) + (control_count + 4 + drain);
	localparam int cycle_limit = 2 * test_cycles;

	logic rclk;
	logic reset;
	logic [a_addr_bits-1:0] a_address;
	word_t a_write_data;
	logic a_write_enable;
	word_t a_read_data;
	logic [b_addr_bits-1:0] b_address;
	byte_t b_read_data;
	word_t control_0;
	word_t control_1;
	word_t control_2;
	word_t control_3;

	`include "tb_checks.svh"

	// expected read results in flight, newest at index 0
	word_t pipe_a [pipe_depth];
	byte_t pipe_b [pipe_depth];
	bit pipe_a_valid [pipe_depth];
	bit pipe_b_valid [pipe_depth];
	// addresses held during idle cycles
	logic [a_addr_bits-1:0] last_a = '0;
	logic [b_addr_bits-1:0] last_b = '0;
	// port A addresses written by the word test
	logic [a_addr_bits-1:0] written [$];
	int cycle_count = 0;

	dual_port_mem i_dual_port_mem (
		.rclk (rclk),
		.reset (reset),
		.a_address (a_address),
		.a_write_data (a_write_data),
		.a_write_enable (a_write_enable),
		.a_read_data (a_read_data),
		.b_address (b_address),
		.b_read_data (b_read_data),
		.control_0 (control_0),
		.control_1 (control_1),
		.control_2 (control_2),
		.control_3 (control_3)
	);

	always #(clock_period / 2) rclk = ~rclk;

	// run limit
	always @(posedge rclk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= cycle_limit) begin
			$display("ERROR: run stopped by timeout after %0d cycles", cycle_count);
			$display("STATUS: FAIL");
			$finish;
		end
	end

	// one clock cycle: drive both ports, check the read from two cycles back
	task automatic drive_cycle(input logic [a_addr_bits-1:0] a_addr, input word_t wdata,
			input logic we, input logic [b_addr_bits-1:0] b_addr);
		bit a_known;
		bit b_known;
		word_t a_expect;
		byte_t b_expect;
		// expected reads see memory before this cycle's write
		a_known = model_has(a_addr);
		b_known = model_has(b_addr[b_addr_bits-1 -: a_addr_bits]);
		a_expect = a_known ? model_word(a_addr) : '0;
		b_expect = b_known ? model_byte(b_addr) : '0;
		@(posedge rclk);
		a_address <= a_addr;
		a_write_data <= wdata;
		a_write_enable <= we;
		b_address <= b_addr;
		last_a = a_addr;
		last_b = b_addr;
		for (int i = pipe_depth - 1; i > 0; i--) begin
			pipe_a[i] = pipe_a[i-1];
			pipe_b[i] = pipe_b[i-1];
			pipe_a_valid[i] = pipe_a_valid[i-1];
			pipe_b_valid[i] = pipe_b_valid[i-1];
		end
		pipe_a[0] = a_expect;
		pipe_b[0] = b_expect;
		pipe_a_valid[0] = a_known;
		pipe_b_valid[0] = b_known;
		@(negedge rclk);
		if (pipe_a_valid[pipe_depth-1]) begin
			compare_word("a_read_data", a_read_data, pipe_a[pipe_depth-1]);
		end
		if (pipe_b_valid[pipe_depth-1]) begin
			compare_byte("b_read_data", b_read_data, pipe_b[pipe_depth-1]);
		end
		// controls reflect writes up to the previous cycle only
		compare_control(0, control_0, model_control[0]);
		compare_control(1, control_1, model_control[1]);
		compare_control(2, control_2, model_control[2]);
		compare_control(3, control_3, model_control[3]);
		if (we) begin
			model_write(a_addr, wdata);
		end
	endtask

	// hold the addresses, no write, lets the pipeline empty
	task automatic idle(input int cycles);
		repeat (cycles) begin
			drive_cycle(last_a, '0, 1'b0, last_b);
		end
	endtask

	task automatic test_reset_state();
		reset <= 1'b1;
		repeat (reset_cycles) @(posedge rclk);
		reset <= 1'b0;
		// last reset edge has just passed
		@(negedge rclk);
		compare_word("a_read_data", a_read_data, '0);
		compare_byte("b_read_data", b_read_data, '0);
		compare_control(0, control_0, '0);
		compare_control(1, control_1, '0);
		compare_control(2, control_2, '0);
		compare_control(3, control_3, '0);
	endtask

	task automatic test_word_write_read();
		logic [a_addr_bits-1:0] addr;
		logic [word_addr_bits-1:0] word_index;
		// two writes per bank, random word index
		for (int i = 0; i < word_count; i++) begin
			word_index = word_addr_bits'($urandom_range(0, (1 << word_addr_bits) - 1));
			addr = {bank_sel_t'(i % bank_count), word_index};
			written.push_back(addr);
			drive_cycle(addr, word_t'($urandom()), 1'b1, last_b);
		end
		foreach (written[i]) begin
			drive_cycle(written[i], '0, 1'b0, last_b);
		end
		idle(drain);
	endtask

	task automatic test_byte_view();
		foreach (written[i]) begin
			for (int lane = 0; lane < (1 << lane_bits); lane++) begin
				drive_cycle(written[i], '0, 1'b0, {written[i], lane_bits'(lane)});
			end
		end
		idle(drain);
	endtask

	// a new address every cycle on both ports
	task automatic test_back_to_back();
		int ia;
		int ib;
		logic [lane_bits-1:0] lane;
		for (int i = 0; i < burst_length; i++) begin
			ia = $urandom_range(0, written.size() - 1);
			ib = $urandom_range(0, written.size() - 1);
			lane = lane_bits'($urandom_range(0, (1 << lane_bits) - 1));
			drive_cycle(written[ia], '0, 1'b0, {written[ib], lane});
		end
		idle(drain);
	endtask

	// same-cycle read returns the old word, next cycle the new one
	task automatic test_read_before_write();
		logic [a_addr_bits-1:0] addr;
		logic [b_addr_bits-1:0] byte_addr;
		word_t fresh;
		for (int i = 0; i < rbw_count; i++) begin
			addr = written[i];
			byte_addr = {addr, lane_bits'(i)};
			// inverted so every bit changes
			fresh = ~model_word(addr);
			drive_cycle(addr, fresh, 1'b1, byte_addr);
			drive_cycle(addr, '0, 1'b0, byte_addr);
		end
		idle(drain);
	endtask

	task automatic test_control_window();
		for (int i = 0; i < control_count; i++) begin
			drive_cycle({bank_sel_t'(0), word_addr_bits'(i)}, word_t'($urandom()), 1'b1, last_b);
		end
		// just outside the window, controls must hold
		drive_cycle({bank_sel_t'(1), word_addr_bits'(0)}, word_t'($urandom()), 1'b1, last_b);
		drive_cycle({bank_sel_t'(0), word_addr_bits'(4)}, word_t'($urandom()), 1'b1, last_b);
		drive_cycle({bank_sel_t'(0), word_addr_bits'(511)}, word_t'($urandom()), 1'b1, last_b);
		drive_cycle({bank_sel_t'(7), word_addr_bits'(3)}, word_t'($urandom()), 1'b1, last_b);
		idle(drain);
	endtask

	initial begin
		rclk = 1'b0;
		reset = 1'b1;
		a_address = '0;
		a_write_data = '0;
		a_write_enable = 1'b0;
		b_address = '0;
		void'($urandom(random_seed));
		test_reset_state();
		test_word_write_read();
		test_byte_view();
		test_back_to_back();
		test_read_before_write();
		test_control_window();
		$display("checks run %0d, errors %0d", check_count, error_count);
		if (error_count == 0) begin
			$display("STATUS: PASS");
		end else begin
			$display("STATUS: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire
